// ==== project.f ====
+incdir+source
+incdir+bench
source/cpl_pkg.sv
source/cpl_ifs.sv
source/pnd_rd_decode.sv
source/cpl_split_fsm.sv
source/cpl_credit_track.sv
source/cpl_hdr_build.sv
source/tlp_txresp_cntrl.sv
bench/tb_txresp.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_txresp -f project.f -o sim_txresp

# the simulator exits non-zero on a failed check, the log decides the result
./obj_dir/sim_txresp > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== bench/tb_txresp_table.svh ====
`ifndef TB_TXRESP_TABLE_SVH
`define TB_TXRESP_TABLE_SVH

// columns: dw_addr, dw_len, fbe, lbe, attr, tc, flush, unsupported, mps_sel,
// beats, delay before beats, busy cycles, full cycles, expected header count
task automatic load_table();
  // single read inside one boundary
  add_row(5'd0, 11'd8, 4'hf, 4'hf, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 2, 3, 0, 0, 1);
  // short read with both byte masks
  add_row(5'd5, 11'd3, 4'he, 4'h3, 2'd1, 3'd2, 1'b0, 1'b0, 1'b0, 1, 2, 0, 0, 1);
  // unaligned read over the boundary, 128 byte middle completions
  add_row(5'd30, 11'd100, 4'hc, 4'h7, 2'd2, 3'd5, 1'b0, 1'b0, 1'b0, 26, 1, 0, 0, 5);
  // same request, 256 byte middle completion
  add_row(5'd30, 11'd100, 4'hc, 4'h7, 2'd2, 3'd5, 1'b0, 1'b0, 1'b1, 26, 1, 0, 0, 3);
  // flush read
  add_row(5'd7, 11'd1, 4'hf, 4'hf, 2'd0, 3'd1, 1'b1, 1'b0, 1'b0, 0, 0, 0, 0, 1);
  // unsupported size, held off by busy for a few cycles
  add_row(5'd2, 11'd16, 4'hf, 4'hf, 2'd3, 3'd7, 1'b0, 1'b1, 1'b0, 0, 0, 4, 0, 1);
  // data late and command FIFO busy
  add_row(5'd3, 11'd6, 4'hf, 4'hf, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 3, 10, 12, 0, 1);
  // command FIFO full for a long window
  add_row(5'd9, 11'd37, 4'h7, 4'h8, 2'd1, 3'd3, 1'b0, 1'b0, 1'b1, 10, 4, 0, 20, 2);
  // aligned read of two boundaries, busy and full together
  add_row(5'd0, 11'd64, 4'hf, 4'hf, 2'd0, 3'd4, 1'b0, 1'b0, 1'b0, 16, 0, 6, 6, 2);
endtask

`endif

// ==== bench/tb_txresp.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

module tb_txresp;

  import cpl_pkg::*;

  localparam int CLK_HALF    = 20;
  localparam int DRIVE_DLY   = 2;
  localparam int NUM_ROWS    = 9;
  localparam int WDOG_CYCLES = NUM_ROWS * 400;

  typedef struct packed {
    logic [4:0]  dw_addr;
    logic [10:0] dw_len;
    logic [3:0]  fbe;
    logic [3:0]  lbe;
    logic [1:0]  attr;
    logic [2:0]  tc;
    logic        flush;
    logic        uns_rd;
    logic        mps_sel;
    int          beats;
    int          delay;
    int          busy_len;
    int          full_len;
    int          exp_hdrs;
  } row_t;

  logic                       AvlClk_i;
  logic                       Rstn_i;
  logic                       RxPndgRdFifoEmpty_i;
  logic [`PND_WORD_W-1:0]     RxPndgRdFifoDato_i;
  logic                       RxPndgRdFifoRdReq_o;
  logic                       TxReadDataValid_i;
  logic [`CPL_HDR_W-1:0]      CplReqHeader_o;
  logic                       CplReqWr_o;
  logic [`CMD_USEDW_W-1:0]    CmdFifoUsedw_i;
  logic [`CPLBUFF_ADDR_W-1:0] CplRamWrAddr_o;
  logic                       CmdFifoBusy_i;
  logic [`DEVCSR_W-1:0]       DevCsr_i;
  logic                       TxRespIdle_o;

  row_t                  rows[$];
  logic [`CPL_HDR_W-1:0] exp_q[$];
  int                    beats_seen;
  int                    row_beats;
  logic                  blocked_prev;

  tlp_txresp_cntrl u_tlp_txresp_cntrl (
    .AvlClk_i            (AvlClk_i),
    .Rstn_i              (Rstn_i),
    .RxPndgRdFifoEmpty_i (RxPndgRdFifoEmpty_i),
    .RxPndgRdFifoDato_i  (RxPndgRdFifoDato_i),
    .RxPndgRdFifoRdReq_o (RxPndgRdFifoRdReq_o),
    .TxReadDataValid_i   (TxReadDataValid_i),
    .CplReqHeader_o      (CplReqHeader_o),
    .CplReqWr_o          (CplReqWr_o),
    .CmdFifoUsedw_i      (CmdFifoUsedw_i),
    .CplRamWrAddr_o      (CplRamWrAddr_o),
    .CmdFifoBusy_i       (CmdFifoBusy_i),
    .DevCsr_i            (DevCsr_i),
    .TxRespIdle_o        (TxRespIdle_o)
  );

  always #CLK_HALF AvlClk_i = ~AvlClk_i;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic check_hdr(input string name, input logic [`CPL_HDR_W-1:0] got,
                           input logic [`CPL_HDR_W-1:0] exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [`CPLBUFF_ADDR_W-1:0] got,
                            input logic [`CPLBUFF_ADDR_W-1:0] exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic add_row(input logic [4:0] dw_addr, input logic [10:0] dw_len,
                         input logic [3:0] fbe, input logic [3:0] lbe,
                         input logic [1:0] attr, input logic [2:0] tc,
                         input logic flush, input logic uns_rd, input logic mps_sel,
                         input int beats, input int delay, input int busy_len,
                         input int full_len, input int exp_hdrs);
    row_t r;
    r.dw_addr  = dw_addr;
    r.dw_len   = dw_len;
    r.fbe      = fbe;
    r.lbe      = lbe;
    r.attr     = attr;
    r.tc       = tc;
    r.flush    = flush;
    r.uns_rd   = uns_rd;
    r.mps_sel  = mps_sel;
    r.beats    = beats;
    r.delay    = delay;
    r.busy_len = busy_len;
    r.full_len = full_len;
    r.exp_hdrs = exp_hdrs;
    rows.push_back(r);
  endtask

  `include "tb_txresp_table.svh"

  function automatic logic [`PND_WORD_W-1:0] pack_word(input row_t r, input logic [7:0] tag,
                                                      input logic [15:0] rid);
    logic [`PND_WORD_W-1:0] w;
    w = '0;
    w[`PND_TAG_MSB:`PND_TAG_LSB]       = tag;
    w[`PND_DWADDR_MSB:`PND_DWADDR_LSB] = r.dw_addr;
    w[`PND_FLUSH_BIT]                  = r.flush;
    w[`PND_REQID_MSB:`PND_REQID_LSB]   = rid;
    w[`PND_DWLEN_MSB:`PND_DWLEN_LSB]   = r.dw_len;
    w[`PND_FBE_MSB:`PND_FBE_LSB]       = r.fbe;
    w[`PND_ATTR_MSB:`PND_ATTR_LSB]     = r.attr;
    w[`PND_TC_MSB:`PND_TC_LSB]         = r.tc;
    w[`PND_LBE_MSB:`PND_LBE_LSB]       = r.lbe;
    w[`PND_UNS_BIT]                    = r.uns_rd;
    return w;
  endfunction

  function automatic logic [`CPL_HDR_W-1:0] make_hdr(input row_t r, input logic [7:0] tag,
                                                    input logic [15:0] rid, input int bytes,
                                                    input int remain, input logic [6:0] la);
    logic [8:0] len_field;
    len_field = r.uns_rd ? 9'd0 : 9'(bytes / 4);
    return {3'b000, r.attr, len_field, r.tc, 12'(remain), r.flush, 1'b1, 4'h0, 32'h0,
            r.uns_rd, rid, tag, la};
  endfunction

  // expected header sequence of one request
  task automatic predict(input row_t r, input logic [7:0] tag, input logic [15:0] rid);
    int         curr;
    int         rcb;
    int         mps;
    int         fmask;
    int         lmask;
    int         size;
    logic       first;
    logic [6:0] la;
    curr  = int'(r.dw_len) * 4;
    rcb   = `RCB_BYTES - int'(r.dw_addr) * 4;
    mps   = r.mps_sel ? `MAX_PLD_LARGE : `MAX_PLD_SMALL;
    fmask = int'(first_byte_mask(r.fbe));
    lmask = int'(last_byte_mask(r.lbe));
    la    = lower_address(r.dw_addr, r.fbe, r.flush);
    if (r.flush)
      exp_q.push_back(make_hdr(r, tag, rid, 4, 1, la));
    else if (r.uns_rd)
      exp_q.push_back(make_hdr(r, tag, rid, 0, curr - fmask - lmask, la));
    else
    begin
      first = 1'b1;
      while (curr > 0)
      begin
        if (first)
          size = (curr > rcb) ? rcb : curr;
        else
          size = (curr > mps) ? mps : curr;
        exp_q.push_back(make_hdr(r, tag, rid, size, curr - lmask - (first ? fmask : 0),
                                 first ? la : 7'd0));
        curr  = curr - size;
        first = 1'b0;
      end
    end
  endtask

  // header, back-pressure and beat monitor at the falling clock edge
  always @(negedge AvlClk_i)
  begin
    if (Rstn_i)
    begin
      if (TxReadDataValid_i)
        beats_seen = beats_seen + 1;
      if (CplReqWr_o)
      begin
        if (blocked_prev)
          report_problem("header written while the command FIFO was busy or full");
        if (row_beats > 0 && beats_seen == 0)
          report_problem("header written before any read data came back");
        if (exp_q.size() == 0)
          report_problem("header written when none was expected");
        check_hdr("CplReqHeader_o", CplReqHeader_o, exp_q.pop_front());
      end
      blocked_prev = CmdFifoBusy_i || (CmdFifoUsedw_i >= `CMD_FIFO_LIMIT);
    end
  end

  initial
  begin
    #(WDOG_CYCLES * 2 * CLK_HALF);
    report_problem("timeout, the controller stopped issuing headers");
  end

  initial
  begin
    row_t        r;
    logic [7:0]  tag;
    logic [15:0] rid;
    int          span;
    int          total_beats;
    void'($urandom(32'h84cb1f84));
    AvlClk_i            = 1'b0;
    Rstn_i              = 1'b0;
    RxPndgRdFifoEmpty_i = 1'b1;
    RxPndgRdFifoDato_i  = '0;
    TxReadDataValid_i   = 1'b0;
    CmdFifoUsedw_i      = '0;
    CmdFifoBusy_i       = 1'b0;
    DevCsr_i            = '0;
    beats_seen          = 0;
    row_beats           = 0;
    blocked_prev        = 1'b0;
    total_beats         = 0;
    repeat (5) @(posedge AvlClk_i);
    #DRIVE_DLY Rstn_i = 1'b1;
    @(posedge AvlClk_i);
    #DRIVE_DLY;
    check_bit("CplReqWr_o", CplReqWr_o, 1'b0);
    check_bit("RxPndgRdFifoRdReq_o", RxPndgRdFifoRdReq_o, 1'b0);
    check_addr("CplRamWrAddr_o", CplRamWrAddr_o, '0);
    check_bit("TxRespIdle_o", TxRespIdle_o, 1'b1);
    load_table();
    foreach (rows[i])
    begin
      r   = rows[i];
      tag = 8'($urandom);
      rid = 16'($urandom);
      predict(r, tag, rid);
      check_count("model header count", exp_q.size(), r.exp_hdrs);
      row_beats  = r.beats;
      beats_seen = 0;
      DevCsr_i   = '0;
      DevCsr_i[`DEVCSR_MPS_LSB] = r.mps_sel;
      RxPndgRdFifoEmpty_i = 1'b0;
      // the read pulse comes one cycle after the FIFO turns non-empty
      @(posedge AvlClk_i);
      #DRIVE_DLY;
      check_bit("RxPndgRdFifoRdReq_o", RxPndgRdFifoRdReq_o, 1'b1);
      check_bit("TxRespIdle_o", TxRespIdle_o, 1'b0);
      RxPndgRdFifoEmpty_i = 1'b1;
      @(posedge AvlClk_i);
      #DRIVE_DLY;
      check_bit("RxPndgRdFifoRdReq_o", RxPndgRdFifoRdReq_o, 1'b0);
      // the word is valid from the cycle after the read pulse
      RxPndgRdFifoDato_i = pack_word(r, tag, rid);
      span = r.delay + r.beats;
      if (r.busy_len > span)
        span = r.busy_len;
      if (r.full_len > span)
        span = r.full_len;
      for (int c = 0; c < span; c++)
      begin
        CmdFifoBusy_i     = (c < r.busy_len);
        CmdFifoUsedw_i    = (c < r.full_len) ? 4'd8 : 4'd3;
        TxReadDataValid_i = (c >= r.delay) && (c < r.delay + r.beats);
        @(posedge AvlClk_i);
        #DRIVE_DLY;
      end
      CmdFifoBusy_i     = 1'b0;
      CmdFifoUsedw_i    = 4'd0;
      TxReadDataValid_i = 1'b0;
      total_beats       = total_beats + r.beats;
      while (exp_q.size() > 0)
      begin
        @(posedge AvlClk_i);
        #DRIVE_DLY;
      end
      // back in idle two cycles after the last header
      repeat (2) @(posedge AvlClk_i);
      #DRIVE_DLY;
      check_bit("TxRespIdle_o", TxRespIdle_o, 1'b1);
      check_addr("CplRamWrAddr_o", CplRamWrAddr_o, 9'(total_beats % 512));
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== source/tlp_txresp_cntrl.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

module tlp_txresp_cntrl
(
  input  logic                       AvlClk_i,
  input  logic                       Rstn_i,
  input  logic                       RxPndgRdFifoEmpty_i,
  input  logic [`PND_WORD_W-1:0]     RxPndgRdFifoDato_i,
  output logic                       RxPndgRdFifoRdReq_o,
  input  logic                       TxReadDataValid_i,
  output logic [`CPL_HDR_W-1:0]      CplReqHeader_o,
  output logic                       CplReqWr_o,
  input  logic [`CMD_USEDW_W-1:0]    CmdFifoUsedw_i,
  output logic [`CPLBUFF_ADDR_W-1:0] CplRamWrAddr_o,
  input  logic                       CmdFifoBusy_i,
  input  logic [`DEVCSR_W-1:0]       DevCsr_i,
  output logic                       TxRespIdle_o
);

  logic payload_ok;

  rd_req_if    req_bus ();
  cpl_phase_if phase_bus ();

  pnd_rd_decode u_pnd_rd_decode (
    .AvlClk_i    (AvlClk_i),
    .Rstn_i      (Rstn_i),
    .pnd_word_i  (RxPndgRdFifoDato_i),
    .first_cpl_i (phase_bus.first_cpl),
    .req         (req_bus.src)
  );

  cpl_split_fsm u_cpl_split_fsm (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .pnd_empty_i      (RxPndgRdFifoEmpty_i),
    .dev_csr_i        (DevCsr_i[`DEVCSR_MPS_MSB:`DEVCSR_MPS_LSB]),
    .cmd_fifo_usedw_i (CmdFifoUsedw_i),
    .cmd_fifo_busy_i  (CmdFifoBusy_i),
    .payload_ok_i     (payload_ok),
    .req              (req_bus.snk),
    .phase            (phase_bus.src),
    .rd_req_o         (RxPndgRdFifoRdReq_o),
    .cpl_wr_o         (CplReqWr_o),
    .idle_o           (TxRespIdle_o)
  );

  cpl_credit_track u_cpl_credit_track (
    .AvlClk_i       (AvlClk_i),
    .Rstn_i         (Rstn_i),
    .beat_valid_i   (TxReadDataValid_i),
    .req            (req_bus.snk),
    .phase          (phase_bus.snk),
    .payload_ok_o   (payload_ok),
    .cplbuff_addr_o (CplRamWrAddr_o)
  );

  cpl_hdr_build u_cpl_hdr_build (
    .req       (req_bus.snk),
    .phase     (phase_bus.snk),
    .cpl_hdr_o (CplReqHeader_o)
  );

endmodule

// ==== source/cpl_hdr_build.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

module cpl_hdr_build
(
  rd_req_if.snk                 req,
  cpl_phase_if.snk              phase,
  output logic [`CPL_HDR_W-1:0] cpl_hdr_o
);

  logic [`BCNT_W-1:0] bytes_sent;
  logic [8:0]         hdr_dw_len;

  // payload announced by this header, a flush returns one dword
  always_comb
  begin
    bytes_sent = '0;
    if (phase.send_first)
      bytes_sent = phase.first_bytes;
    else if (phase.send_max)
      bytes_sent = phase.max_bytes;
    else if (phase.send_last && req.flush && !req.uns_rd)
      bytes_sent = `BCNT_W'(4);
    else if (phase.send_last && !req.uns_rd)
      bytes_sent = phase.last_bytes;
  end

  assign hdr_dw_len = req.uns_rd ? 9'd0 : bytes_sent[10:2];

  assign cpl_hdr_o = {3'b000,
                      req.attr,
                      hdr_dw_len,
                      req.tc,
                      phase.remain_bytes,
                      req.flush,
                      1'b1,
                      4'h0,
                      32'h0,
                      req.uns_rd,
                      req.req_id,
                      req.tag,
                      req.lower_addr};

endmodule

// ==== source/cpl_credit_track.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

module cpl_credit_track
(
  input  logic                       AvlClk_i,
  input  logic                       Rstn_i,
  input  logic                       beat_valid_i,
  rd_req_if.snk                      req,
  cpl_phase_if.snk                   phase,
  output logic                       payload_ok_o,
  output logic [`CPLBUFF_ADDR_W-1:0] cplbuff_addr_o
);

  logic [`CREDIT_W-1:0] limit_cntr;
  logic [`CREDIT_W-1:0] consumed_cntr;
  logic [`CREDIT_W-1:0] required_reg;
  logic [`CREDIT_W-1:0] available;
  logic [`BCNT_W-1:0]   actual_bytes;

  // data really taken from the buffer, none for flush or unsupported
  always_comb
  begin
    actual_bytes = '0;
    if (phase.send_first)
      actual_bytes = phase.first_bytes;
    else if (phase.send_max)
      actual_bytes = phase.max_bytes;
    else if (phase.send_last && !req.flush && !req.uns_rd)
      actual_bytes = phase.last_bytes;
  end

  // bytes returned from avalon
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      limit_cntr <= '0;
    else if (beat_valid_i)
      limit_cntr <= limit_cntr + `CREDIT_W'(`BYTES_PER_BEAT);
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      consumed_cntr <= '0;
    else if (phase.load && !req.flush && !req.uns_rd)
      consumed_cntr <= consumed_cntr + `CREDIT_W'(req.over_rd);
    else if (phase.send_first || phase.send_max || phase.send_last)
      consumed_cntr <= consumed_cntr + actual_bytes[`CREDIT_W-1:0];
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      required_reg <= '0;
    else if (phase.wait_first)
      required_reg <= consumed_cntr + phase.first_bytes[`CREDIT_W-1:0];
    else if (phase.wait_max)
      required_reg <= consumed_cntr + phase.max_bytes[`CREDIT_W-1:0];
    else if (phase.wait_last)
      required_reg <= consumed_cntr + phase.last_bytes[`CREDIT_W-1:0];
  end

  // a shortfall wraps past the window
  assign available = limit_cntr - required_reg;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      payload_ok_o <= 1'b0;
    else
      payload_ok_o <= phase.pipe && (available <= `CREDIT_WINDOW);
  end

  // one buffer line per beat, wraps at the buffer depth
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      cplbuff_addr_o <= '0;
    else if (beat_valid_i)
      cplbuff_addr_o <= cplbuff_addr_o + 1'b1;
  end

endmodule

// ==== source/cpl_split_fsm.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

module cpl_split_fsm
(
  input  logic                    AvlClk_i,
  input  logic                    Rstn_i,
  input  logic                    pnd_empty_i,
  input  logic [`MPS_SEL_W-1:0]   dev_csr_i,
  input  logic [`CMD_USEDW_W-1:0] cmd_fifo_usedw_i,
  input  logic                    cmd_fifo_busy_i,
  input  logic                    payload_ok_i,
  rd_req_if.snk                   req,
  cpl_phase_if.src                phase,
  output logic                    rd_req_o,
  output logic                    cpl_wr_o,
  output logic                    idle_o
);

  // one-hot state bit positions
  localparam int s_idle       = 0;
  localparam int s_read       = 1;
  localparam int s_load       = 2;
  localparam int s_wait_data  = 3;
  localparam int s_send_first = 4;
  localparam int s_send_last  = 5;
  localparam int s_send_max   = 6;
  localparam int s_done       = 7;
  localparam int s_wait_first = 8;
  localparam int s_wait_max   = 9;
  localparam int s_wait_last  = 10;
  localparam int s_pipe_first = 11;
  localparam int s_pipe_max   = 12;
  localparam int s_pipe_last  = 13;

  logic [13:0]        state;
  logic [13:0]        state_nxt;
  logic               cmd_ok;
  logic               first_sreg;
  logic [`BCNT_W-1:0] curr_bcnt;
  logic [`BCNT_W-1:0] max_payload;
  logic [`BCNT_W-1:0] rcb_bytes;

  assign cmd_ok      = !cmd_fifo_busy_i && (cmd_fifo_usedw_i < `CMD_FIFO_LIMIT);
  assign max_payload = (dev_csr_i == 3'b000) ? `BCNT_W'(`MAX_PLD_SMALL) :
                                               `BCNT_W'(`MAX_PLD_LARGE);
  assign rcb_bytes   = `BCNT_W'(req.bytes_to_rcb);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state <= 14'd1 << s_idle;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = '0;
    case (1'b1)
      state[s_idle]:
        state_nxt[pnd_empty_i ? s_idle : s_read] = 1'b1;
      state[s_read]:
        state_nxt[s_load] = 1'b1;
      state[s_load]:
        state_nxt[s_wait_data] = 1'b1;
      state[s_wait_data]:
      begin
        if (!cmd_ok)
          state_nxt[s_wait_data] = 1'b1;
        else if (first_sreg && (req.flush || req.uns_rd))
          state_nxt[s_send_last] = 1'b1;
        else if (first_sreg)
          state_nxt[(curr_bcnt > rcb_bytes) ? s_wait_first : s_wait_last] = 1'b1;
        else
          state_nxt[(curr_bcnt > max_payload) ? s_wait_max : s_wait_last] = 1'b1;
      end
      state[s_wait_first]:
        state_nxt[s_pipe_first] = 1'b1;
      state[s_wait_max]:
        state_nxt[s_pipe_max] = 1'b1;
      state[s_wait_last]:
        state_nxt[s_pipe_last] = 1'b1;
      state[s_pipe_first]:
        state_nxt[(payload_ok_i && cmd_ok) ? s_send_first : s_pipe_first] = 1'b1;
      state[s_pipe_max]:
        state_nxt[(payload_ok_i && cmd_ok) ? s_send_max : s_pipe_max] = 1'b1;
      state[s_pipe_last]:
        state_nxt[(payload_ok_i && cmd_ok) ? s_send_last : s_pipe_last] = 1'b1;
      state[s_send_first]:
        state_nxt[s_wait_data] = 1'b1;
      state[s_send_max]:
        state_nxt[s_wait_data] = 1'b1;
      state[s_send_last]:
        state_nxt[s_done] = 1'b1;
      default:
        state_nxt[s_idle] = 1'b1;
    endcase
  end

  // set at load, cleared once the first header is out
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      first_sreg <= 1'b0;
    else if (state[s_load])
      first_sreg <= 1'b1;
    else if (state[s_send_first] || state[s_send_last])
      first_sreg <= 1'b0;
  end

  // bytes still to be completed
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      curr_bcnt <= '0;
    else if (state[s_load])
      curr_bcnt <= {req.dw_len, 2'b00};
    else if (state[s_send_first])
      curr_bcnt <= curr_bcnt - rcb_bytes;
    else if (state[s_send_max])
      curr_bcnt <= curr_bcnt - max_payload;
    else if (state[s_send_last])
      curr_bcnt <= '0;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      phase.first_bytes  <= '0;
      phase.max_bytes    <= '0;
      phase.last_bytes   <= '0;
      phase.remain_bytes <= '0;
    end
    else
    begin
      phase.first_bytes  <= rcb_bytes;
      phase.max_bytes    <= max_payload;
      phase.last_bytes   <= curr_bcnt;
      // the masks trim the header byte count to the enabled bytes
      phase.remain_bytes <= req.flush ? 12'd1 : curr_bcnt[11:0] - 12'(req.bytes_mask);
    end
  end

  assign phase.load       = state[s_load];
  assign phase.wait_first = state[s_wait_first];
  assign phase.wait_max   = state[s_wait_max];
  assign phase.wait_last  = state[s_wait_last];
  assign phase.pipe       = state[s_pipe_first] | state[s_pipe_max] | state[s_pipe_last];
  assign phase.send_first = state[s_send_first];
  assign phase.send_max   = state[s_send_max];
  assign phase.send_last  = state[s_send_last];
  // high one cycle early so the decoder registers the first byte mask
  assign phase.first_cpl  = state[s_load] | first_sreg;

  assign rd_req_o = state[s_read];
  assign cpl_wr_o = state[s_send_first] | state[s_send_max] | state[s_send_last];
  assign idle_o   = state[s_idle] & pnd_empty_i;

endmodule

// ==== source/pnd_rd_decode.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

module pnd_rd_decode
(
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  logic [`PND_WORD_W-1:0] pnd_word_i,
  input  logic                   first_cpl_i,
  rd_req_if.src                  req
);

  import cpl_pkg::*;

  logic [4:0] dw_addr;
  logic [6:0] rd_addr;
  logic [3:0] fbe;
  logic [3:0] lbe;
  logic [2:0] mask_sum;

  assign dw_addr = pnd_word_i[`PND_DWADDR_MSB:`PND_DWADDR_LSB];
  assign rd_addr = {dw_addr, 2'b00};
  assign fbe     = pnd_word_i[`PND_FBE_MSB:`PND_FBE_LSB];
  assign lbe     = pnd_word_i[`PND_LBE_MSB:`PND_LBE_LSB];

  // fields taken straight from the FIFO word
  assign req.tag    = pnd_word_i[`PND_TAG_MSB:`PND_TAG_LSB];
  assign req.req_id = pnd_word_i[`PND_REQID_MSB:`PND_REQID_LSB];
  assign req.attr   = pnd_word_i[`PND_ATTR_MSB:`PND_ATTR_LSB];
  assign req.tc     = pnd_word_i[`PND_TC_MSB:`PND_TC_LSB];
  assign req.dw_len = pnd_word_i[`PND_DWLEN_MSB:`PND_DWLEN_LSB];
  assign req.flush  = pnd_word_i[`PND_FLUSH_BIT];
  assign req.uns_rd = pnd_word_i[`PND_UNS_BIT];

  // used once, at load time
  assign req.over_rd = over_read_bytes(rd_addr[3:0], req.dw_len[1:0], |req.dw_len[10:2]);

  // only the first completion loses the leading disabled bytes
  assign mask_sum = (first_cpl_i ? {1'b0, first_byte_mask(fbe)} : 3'd0) +
                    {1'b0, last_byte_mask(lbe)};

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      req.bytes_to_rcb <= 8'd0;
      req.bytes_mask   <= 3'd0;
      req.lower_addr   <= 7'd0;
    end
    else
    begin
      req.bytes_to_rcb <= 8'(`RCB_BYTES) - {1'b0, rd_addr};
      req.bytes_mask   <= mask_sum;
      // later completions start on a boundary
      req.lower_addr   <= first_cpl_i ? lower_address(dw_addr, fbe, req.flush) : 7'd0;
    end
  end

endmodule

// ==== source/cpl_ifs.sv ====
`timescale 1ns/100ps
`include "cpl_defs.svh"

// decoded fields of the pending read in service
interface rd_req_if;
  logic [7:0]  tag;
  logic [15:0] req_id;
  logic [1:0]  attr;
  logic [2:0]  tc;
  logic [10:0] dw_len;
  logic        flush;
  logic        uns_rd;
  logic [7:0]  bytes_to_rcb;
  logic [2:0]  bytes_mask;
  logic [4:0]  over_rd;
  logic [6:0]  lower_addr;

  modport src (output tag, req_id, attr, tc, dw_len, flush, uns_rd,
               bytes_to_rcb, bytes_mask, over_rd, lower_addr);
  modport snk (input tag, req_id, attr, tc, dw_len, flush, uns_rd,
               bytes_to_rcb, bytes_mask, over_rd, lower_addr);
endinterface

// FSM phase strobes and per-completion sizes
interface cpl_phase_if;
  logic              load;
  logic              wait_first;
  logic              wait_max;
  logic              wait_last;
  logic              pipe;
  logic              send_first;
  logic              send_max;
  logic              send_last;
  logic [`BCNT_W-1:0] first_bytes;
  logic [`BCNT_W-1:0] max_bytes;
  logic [`BCNT_W-1:0] last_bytes;
  logic [11:0]       remain_bytes;
  logic              first_cpl;

  modport src (output load, wait_first, wait_max, wait_last, pipe, send_first,
               send_max, send_last, first_bytes, max_bytes, last_bytes,
               remain_bytes, first_cpl);
  modport snk (input load, wait_first, wait_max, wait_last, pipe, send_first,
               send_max, send_last, first_bytes, max_bytes, last_bytes,
               remain_bytes, first_cpl);
endinterface

// ==== source/cpl_pkg.sv ====
package cpl_pkg;

  // bytes dropped from the byte count by the first byte enable
  function automatic logic [1:0] first_byte_mask(input logic [3:0] fbe);
    case (fbe)
      4'b0001, 4'b0010, 4'b0100, 4'b1000:
        return 2'd3;
      4'b0011, 4'b0110, 4'b1100:
        return 2'd2;
      4'b0111, 4'b1110:
        return 2'd1;
      default:
        return 2'd0;
    endcase
  endfunction

  // trailing bytes dropped by the last byte enable
  function automatic logic [1:0] last_byte_mask(input logic [3:0] lbe);
    case (lbe)
      4'b0111:
        return 2'd1;
      4'b0011:
        return 2'd2;
      4'b0001:
        return 2'd3;
      default:
        return 2'd0;
    endcase
  endfunction

  // avalon reads whole 16-byte lines, so some data comes back unused
  function automatic logic [4:0] over_read_bytes(input logic [3:0] addr_lo,
                                                 input logic [1:0] len_lo,
                                                 input logic       len_gte4);
    logic [4:0] bytes;
    bytes = 5'd0;
    if (addr_lo[1:0] == 2'b00)
    begin
      case (len_lo)
        2'b00:
          bytes = (len_gte4 && addr_lo[3:2] != 2'b00) ? 5'd16 : 5'd0;
        2'b01:
          bytes = 5'd12;
        2'b10:
          bytes = (addr_lo[3:2] == 2'b11) ? 5'd24 : 5'd8;
        default:
          bytes = addr_lo[3] ? 5'd20 : 5'd4;
      endcase
    end
    return bytes;
  endfunction

  // address of the first enabled byte, a flush points at its dword
  function automatic logic [6:0] lower_address(input logic [4:0] dw_addr,
                                               input logic [3:0] fbe,
                                               input logic       flush);
    if (flush)
      return {dw_addr, 2'b00};
    else if (fbe[0])
      return {dw_addr, 2'b00};
    else if (fbe[1])
      return {dw_addr, 2'b01};
    else if (fbe[2])
      return {dw_addr, 2'b10};
    else if (fbe[3])
      return {dw_addr, 2'b11};
    else
      return 7'd0;
  endfunction

endpackage

// ==== source/cpl_defs.svh ====
`ifndef CPL_DEFS_SVH
`define CPL_DEFS_SVH

// word widths
`define PND_WORD_W       57
`define CPL_HDR_W        99
`define BCNT_W           13
`define CREDIT_W         11
`define CPLBUFF_ADDR_W   9
`define CMD_USEDW_W      4
`define DEVCSR_W         32

// completion sizing
`define RCB_BYTES        128
`define BYTES_PER_BEAT   16
`define CREDIT_WINDOW    1024
`define CMD_FIFO_LIMIT   8
`define MAX_PLD_SMALL    128
`define MAX_PLD_LARGE    256

// max payload selector inside the device control register
`define DEVCSR_MPS_MSB   7
`define DEVCSR_MPS_LSB   5
`define MPS_SEL_W        3

// pending read word fields
`define PND_TAG_MSB      7
`define PND_TAG_LSB      0
`define PND_DWADDR_MSB   14
`define PND_DWADDR_LSB   10
`define PND_FLUSH_BIT    15
`define PND_REQID_MSB    31
`define PND_REQID_LSB    16
`define PND_DWLEN_MSB    42
`define PND_DWLEN_LSB    32
`define PND_FBE_MSB      46
`define PND_FBE_LSB      43
`define PND_ATTR_MSB     48
`define PND_ATTR_LSB     47
`define PND_TC_MSB       51
`define PND_TC_LSB       49
`define PND_LBE_MSB      55
`define PND_LBE_LSB      52
`define PND_UNS_BIT      56

`endif
